// ==== include/obi_support_config.svh ====
// obi observer sizing: outstanding depth, count and address widths, drain time
`ifndef OBI_SUPPORT_CONFIG_SVH
`define OBI_SUPPORT_CONFIG_SVH

// attribute store depth, also the highest legal outstanding count
`define OBI_MAX_OUTSTANDING 4

// width of the outstanding counter, must hold OBI_MAX_OUTSTANDING
`define OBI_CNT_W 3

// fetch address width on the instruction bus
`define OBI_ADDR_W 32

// idle cycles between testbench runs so the buses empty out
`define OBI_DRAIN_CYCLES 8

`endif

// ==== logic/obi_bus_pkg.sv ====
// obi bus types: observed strobes and the per-request attributes of each bus
`include "obi_support_config.svh"

package obi_bus_pkg;

  // ----------------------------------------
  // handshake as seen on one bus
  // ----------------------------------------
  typedef struct packed {
    logic req;
    logic gnt;
    logic gntpar;
    logic rvalid;
  } obi_strobes_t;

  // ----------------------------------------
  // attributes carried from grant to response
  // ----------------------------------------

  // data bus, one entry per granted load or store
  typedef struct packed {
    logic was_store;
    logic gntpar_err;
  } data_attr_t;

  // instruction bus, one entry per granted fetch
  typedef struct packed {
    logic [`OBI_ADDR_W-1:0] addr;
    logic                   gntpar_err;
  } instr_attr_t;

endpackage

// ==== logic/obi_monitor_pkg.sv ====
// obi observer types: address-phase state and per-bus status
`include "obi_support_config.svh"

package obi_monitor_pkg;

  // address phase of the request on the bus
  // stall means last cycle had req without gnt
  typedef enum logic {
    ADDR_IDLE  = 1'b0,
    ADDR_STALL = 1'b1
  } addr_phase_e;

  // ----------------------------------------
  // status reported for one bus
  // ----------------------------------------
  typedef struct packed {
    logic                  addr_ph_cont;
    logic                  resp_ph_cont;
    logic [`OBI_CNT_W-1:0] v_addr_ph_cnt;
  } obi_status_t;

endpackage

// ==== logic/obi_phase_monitor.sv ====
// obi phase monitor: address-phase state, continuation flags and outstanding count
`timescale 1ns/100ps
`include "obi_support_config.svh"

module obi_phase_monitor
  import obi_bus_pkg::*;
  import obi_monitor_pkg::*;
(
  input  logic         in_support_if,
  input  logic         reset_i,
  input  obi_strobes_t bus_i,
  output obi_status_t  status_o
);

  addr_phase_e           state_q;
  addr_phase_e           state_d;
  logic [`OBI_CNT_W-1:0] cnt_q;
  logic                  grant;
  logic                  resp;

  assign grant = bus_i.req && bus_i.gnt;
  assign resp  = bus_i.rvalid;

  // ----------------------------------------
  // address phase state
  // ----------------------------------------

  // a request held without grant stalls into the next cycle
  always_comb begin
    if (bus_i.req && !bus_i.gnt) begin
      state_d = ADDR_STALL;
    end else begin
      state_d = ADDR_IDLE;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      state_q <= ADDR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // outstanding transfers
  // ----------------------------------------

  // grant and response in one cycle cancel out
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (grant && !resp) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (resp && !grant) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign status_o.addr_ph_cont  = bus_i.req && (state_q == ADDR_STALL);
  assign status_o.resp_ph_cont  = (cnt_q != '0) && !bus_i.rvalid;
  assign status_o.v_addr_ph_cnt = cnt_q;

  // the bus may never run more transfers than the attribute stores hold
  a_cnt_bounded : assert property (
    @(posedge in_support_if) disable iff (reset_i)
    cnt_q <= `OBI_MAX_OUTSTANDING
  );

  // every response must belong to an earlier grant
  a_no_orphan_resp : assert property (
    @(posedge in_support_if) disable iff (reset_i)
    bus_i.rvalid |-> (cnt_q != '0)
  );

endmodule

// ==== logic/obi_gntpar_tracker.sv ====
// grant parity tracker: flags a request whose gntpar matched gnt in its address phase
`timescale 1ns/100ps

module obi_gntpar_tracker
  import obi_bus_pkg::*;
(
  input  logic         in_support_if,
  input  logic         reset_i,
  input  obi_strobes_t bus_i,
  output logic         gntpar_err_o
);

  // error seen in an earlier stalled cycle of the pending request
  logic err_q;
  logic parity_bad;

  // gntpar is the inverse of gnt when healthy
  assign parity_bad = (bus_i.gntpar == bus_i.gnt);

  assign gntpar_err_o = bus_i.req && (parity_bad || err_q);

  // record only lives across stalls, cleared on grant or dropped req
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      err_q <= gntpar_err_o;
    end else begin
      err_q <= 1'b0;
    end
  end

  // a recorded error implies the request is still held
  a_err_needs_req : assert property (
    @(posedge in_support_if) disable iff (reset_i)
    err_q |-> bus_i.req
  );

endmodule

// ==== logic/obi_attr_fifo.sv ====
// request attribute store: captures attributes at grant, returns them with responses in order
`timescale 1ns/100ps
`include "obi_support_config.svh"

module obi_attr_fifo
  import obi_bus_pkg::*;
#(
  parameter type attr_t = logic
) (
  input  logic         in_support_if,
  input  logic         reset_i,
  input  obi_strobes_t bus_i,
  input  attr_t        attr_i,
  output attr_t        resp_attr_o
);

  localparam int DEPTH = `OBI_MAX_OUTSTANDING;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  attr_t                 mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [`OBI_CNT_W-1:0] fill_q;
  logic                  push;
  logic                  pop;
  logic                  full;
  logic                  empty;

  assign push  = bus_i.req && bus_i.gnt;
  assign pop   = bus_i.rvalid;
  assign full  = (fill_q == `OBI_CNT_W'(DEPTH));
  assign empty = (fill_q == '0);

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // ----------------------------------------
  // pointers and fill level
  // ----------------------------------------
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop && !push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // head entry only shows during a response
  assign resp_attr_o = pop ? mem_q[rd_ptr_q] : '0;

  // bus must not grant beyond the store depth
  a_no_push_full : assert property (
    @(posedge in_support_if) disable iff (reset_i)
    push |-> !full
  );

  // responses must match earlier grants
  a_no_pop_empty : assert property (
    @(posedge in_support_if) disable iff (reset_i)
    pop |-> !empty
  );

endmodule

// ==== logic/obi_support_top.sv ====
// obi support top: phase, parity and attribute observers for the data and instruction buses
`timescale 1ns/100ps
`include "obi_support_config.svh"

module obi_support_top
  import obi_bus_pkg::*;
  import obi_monitor_pkg::*;
(
  input  logic                   in_support_if,
  input  logic                   reset_i,
  input  obi_strobes_t           data_bus_i,
  input  obi_strobes_t           instr_bus_i,
  input  logic                   data_is_store_i,
  input  logic [`OBI_ADDR_W-1:0] instr_addr_i,
  output obi_status_t            data_status_o,
  output obi_status_t            instr_status_o,
  output data_attr_t             data_resp_attr_o,
  output instr_attr_t            instr_resp_attr_o
);

  logic        data_gntpar_err;
  logic        instr_gntpar_err;
  data_attr_t  data_req_attr;
  instr_attr_t instr_req_attr;

  // ----------------------------------------
  // data bus
  // ----------------------------------------
  obi_phase_monitor i_data_phase (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .status_o      (data_status_o)
  );

  obi_gntpar_tracker i_data_gntpar (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .gntpar_err_o  (data_gntpar_err)
  );

  assign data_req_attr.was_store  = data_is_store_i;
  assign data_req_attr.gntpar_err = data_gntpar_err;

  obi_attr_fifo #(
    .attr_t (data_attr_t)
  ) i_data_attr (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (data_bus_i),
    .attr_i        (data_req_attr),
    .resp_attr_o   (data_resp_attr_o)
  );

  // ----------------------------------------
  // instruction bus
  // ----------------------------------------
  obi_phase_monitor i_instr_phase (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .status_o      (instr_status_o)
  );

  obi_gntpar_tracker i_instr_gntpar (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .gntpar_err_o  (instr_gntpar_err)
  );

  // fetch address travels with its parity verdict
  assign instr_req_attr.addr       = instr_addr_i;
  assign instr_req_attr.gntpar_err = instr_gntpar_err;

  obi_attr_fifo #(
    .attr_t (instr_attr_t)
  ) i_instr_attr (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_req_attr),
    .resp_attr_o   (instr_resp_attr_o)
  );

endmodule

// ==== tests/obi_support_tb.sv ====
// obi observer testbench: random legal traffic on both buses checked against a reference model
`timescale 1ns/100ps
`include "obi_support_config.svh"

module obi_support_tb
  import obi_bus_pkg::*;
  import obi_monitor_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int TEST_CYCLES  = 500;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 5 * (TEST_CYCLES + `OBI_DRAIN_CYCLES) + 100;

  logic                   clk;
  logic                   reset;
  obi_strobes_t           data_bus;
  obi_strobes_t           instr_bus;
  logic                   data_is_store;
  logic [`OBI_ADDR_W-1:0] instr_addr;
  obi_status_t            data_status;
  obi_status_t            instr_status;
  data_attr_t             data_resp_attr;
  instr_attr_t            instr_resp_attr;

  logic [31:0] rng;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  // driver side outstanding counts
  int          d_drv_cnt;
  int          i_drv_cnt;
  // reference model state
  data_attr_t  data_q[$];
  instr_attr_t instr_q[$];
  int          d_cnt;
  int          i_cnt;
  bit          d_stall;
  bit          i_stall;
  bit          d_rec;
  bit          i_rec;

  obi_support_top i_dut (
    .in_support_if     (clk),
    .reset_i           (reset),
    .data_bus_i        (data_bus),
    .instr_bus_i       (instr_bus),
    .data_is_store_i   (data_is_store),
    .instr_addr_i      (instr_addr),
    .data_status_o     (data_status),
    .instr_status_o    (instr_status),
    .data_resp_attr_o  (data_resp_attr),
    .instr_resp_attr_o (instr_resp_attr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int roll();
    rng = xorshift(rng);
    return int'(rng % 32'd100);
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic obi_status_t ref_status(input obi_strobes_t b, input int cnt,
                                            input bit stall);
    obi_status_t s;
    s.addr_ph_cont  = b.req && stall;
    s.resp_ph_cont  = (cnt != 0) && !b.rvalid;
    s.v_addr_ph_cnt = `OBI_CNT_W'(cnt);
    return s;
  endfunction

  function automatic bit ref_perr(input obi_strobes_t b, input bit rec);
    return b.req && ((b.gntpar == b.gnt) || rec);
  endfunction

  task automatic advance(input obi_strobes_t b, input bit perr, inout int cnt,
                         inout bit stall, inout bit rec);
    cnt   = cnt + int'(b.req && b.gnt) - int'(b.rvalid);
    stall = b.req && !b.gnt;
    rec   = stall ? perr : 1'b0;
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_status(input string name, input obi_status_t exp, input obi_status_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_data_attr(input data_attr_t exp, input data_attr_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t data_resp_attr_o expected %h got %h", $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_instr_attr(input instr_attr_t exp, input instr_attr_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t instr_resp_attr_o expected %h got %h", $time, exp, act);
      errors++;
    end
  endtask

  // outputs are stable at the rising edge, registers move only after it
  always @(posedge clk) begin : compare_outputs
    data_attr_t  d_exp;
    instr_attr_t i_exp;
    bit          d_perr;
    bit          i_perr;
    d_exp = '0;
    i_exp = '0;
    if (reset) begin
      data_q.delete();
      instr_q.delete();
      d_cnt   = 0;
      i_cnt   = 0;
      d_stall = 1'b0;
      i_stall = 1'b0;
      d_rec   = 1'b0;
      i_rec   = 1'b0;
    end else begin
      check_status("data_status_o", ref_status(data_bus, d_cnt, d_stall), data_status);
      check_status("instr_status_o", ref_status(instr_bus, i_cnt, i_stall), instr_status);
      if (data_bus.rvalid && data_q.size() > 0) d_exp = data_q.pop_front();
      if (instr_bus.rvalid && instr_q.size() > 0) i_exp = instr_q.pop_front();
      check_data_attr(d_exp, data_resp_attr);
      check_instr_attr(i_exp, instr_resp_attr);
      d_perr = ref_perr(data_bus, d_rec);
      i_perr = ref_perr(instr_bus, i_rec);
      if (data_bus.req && data_bus.gnt) begin
        data_q.push_back(data_attr_t'{was_store: data_is_store, gntpar_err: d_perr});
      end
      if (instr_bus.req && instr_bus.gnt) begin
        instr_q.push_back(instr_attr_t'{addr: instr_addr, gntpar_err: i_perr});
      end
      advance(data_bus, d_perr, d_cnt, d_stall, d_rec);
      advance(instr_bus, i_perr, i_cnt, i_stall, i_rec);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  // a stalled request stays up, gnt waits while the stores are full
  task automatic step_bus(inout obi_strobes_t b, inout int cnt, input int req_pct,
                          input int gnt_pct, input int rsp_pct, input int perr_pct,
                          input bit idle, output bit new_req);
    bit granted;
    granted = b.req && b.gnt;
    if (granted) cnt++;
    if (b.rvalid) cnt--;
    new_req = 1'b0;
    if (!b.req || granted) begin
      b.req   = !idle && (roll() < req_pct);
      new_req = b.req;
    end
    b.gnt    = b.req && (cnt < `OBI_MAX_OUTSTANDING) && (roll() < gnt_pct);
    b.gntpar = (roll() < perr_pct) ? b.gnt : !b.gnt;
    b.rvalid = (cnt > 0) && (roll() < rsp_pct);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - errs_before);
    end
  endtask

  // entered on a falling edge, returns once the last driven cycle has been compared
  task automatic run_test(input string name, input int req_pct, input int gnt_pct,
                          input int rsp_pct, input int perr_pct);
    int errs_before;
    bit nd;
    bit ni;
    errs_before = errors;
    for (int c = 0; c < TEST_CYCLES + `OBI_DRAIN_CYCLES; c++) begin
      step_bus(data_bus, d_drv_cnt, req_pct, gnt_pct, rsp_pct, perr_pct, c >= TEST_CYCLES, nd);
      step_bus(instr_bus, i_drv_cnt, req_pct, gnt_pct, rsp_pct, perr_pct, c >= TEST_CYCLES, ni);
      if (nd) data_is_store = (roll() < 50);
      if (ni) begin
        rng        = xorshift(rng);
        instr_addr = rng & ~32'h3;
      end
      @(negedge clk);
    end
    report_test(name, errs_before);
  endtask

  initial begin : run
    int errs_before;
    rng           = 32'he255;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cycles        = 0;
    d_drv_cnt     = 0;
    i_drv_cnt     = 0;
    reset         = 1'b1;
    data_bus      = '0;
    instr_bus     = '0;
    data_is_store = 1'b0;
    instr_addr    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // quiet bus right after reset
    errs_before = errors;
    repeat (RESET_CYCLES) @(negedge clk);
    report_test("reset state", errs_before);
    run_test("steady traffic", 70, 70, 50, 0);
    run_test("heavy stalls", 80, 20, 50, 0);
    run_test("parity errors", 70, 40, 50, 30);
    run_test("deep outstanding", 95, 90, 15, 10);
    run_test("sparse mixed", 25, 60, 40, 15);
    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== obi_support_top.f ====
+incdir+include
logic/obi_bus_pkg.sv
logic/obi_monitor_pkg.sv
logic/obi_phase_monitor.sv
logic/obi_gntpar_tracker.sv
logic/obi_attr_fifo.sv
logic/obi_support_top.sv
tests/obi_support_tb.sv

// ==== Bender.yml ====
package:
  name: obi_support

export_include_dirs:
  - include

sources:
  - files:
      - logic/obi_bus_pkg.sv
      - logic/obi_monitor_pkg.sv
      - logic/obi_phase_monitor.sv
      - logic/obi_gntpar_tracker.sv
      - logic/obi_attr_fifo.sv
      - logic/obi_support_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/obi_support_tb.sv
